//--- logic/dcache_pkg.sv
// geometry, vector types and controller states shared by every data cache module
package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W   = 32;
    localparam int INDEX_W  = 4;
    localparam int OFFSET_W = 2;
    localparam int WAYS     = 2;
    // two byte-select bits sit below the word offset
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W - 2;
    localparam int LINE_W   = 32 << OFFSET_W;
    localparam int SETS     = 1 << INDEX_W;

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [31:0]         word_t;
    typedef logic [3:0]          strb_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] word_sel_t;
    typedef logic [WAYS-1:0]     way_mask_t;

    // controller sequencing
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        WRITE_REQ,
        WRITE_WAIT
    } ctrl_state_t;

endpackage

//--- logic/dcache_tag_ram.sv
// tag and valid store for both ways, read one cycle after the index is presented, with hit compare
`timescale 1ns/100ps

module dcache_tag_ram import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  index_t    rd_index,
    input  tag_t      cmp_tag,
    input  way_mask_t wr_en,
    input  index_t    wr_index,
    input  tag_t      wr_tag,
    output way_mask_t hit
);

    tag_t            tag_mem [WAYS][SETS];
    logic [SETS-1:0] valid   [WAYS];

    // registered read port
    tag_t            rd_tag   [WAYS];
    way_mask_t       rd_valid;

    ////////////////////////////////////////////////////////////
    // valid bits, cleared by reset
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < WAYS; w++) begin
                valid[w] <= '0;
            end
            rd_valid <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                rd_valid[w] <= valid[w][rd_index];
                if (wr_en[w]) begin
                    valid[w][wr_index] <= 1'b1;
                end
            end
        end
    end

    // tag storage itself needs no reset
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            rd_tag[w] <= tag_mem[w][rd_index];
            if (wr_en[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
        end
    end

endmodule

//--- logic/dcache_data_ram.sv
// line store for both ways, read one cycle after the index, filled by whole lines or strobed words
`timescale 1ns/100ps

module dcache_data_ram import dcache_pkg::*; (
    input  logic      clk,
    input  index_t    rd_index,
    input  way_mask_t fill_en,
    input  line_t     fill_line,
    input  way_mask_t wr_en,
    input  index_t    wr_index,
    input  word_sel_t wr_word,
    input  word_t     wr_data,
    input  strb_t     wr_strb,
    output line_t     rd_line0,
    output line_t     rd_line1
);

    line_t line_mem [WAYS][SETS];
    line_t rd_line  [WAYS];

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (fill_en[w]) begin
                line_mem[w][wr_index] <= fill_line;
            end else if (wr_en[w]) begin
                // only the strobed byte lanes of the addressed word change
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        line_mem[w][wr_index][wr_word * 32 + b * 8 +: 8] <= wr_data[b * 8 +: 8];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            rd_line[w] <= line_mem[w][rd_index];
        end
    end

    assign rd_line0 = rd_line[0];
    assign rd_line1 = rd_line[1];

endmodule

//--- logic/dcache_lru.sv
// per-set least recently used bit, touched on each use and queried for the refill victim
`timescale 1ns/100ps

module dcache_lru import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   touch_en,
    input  index_t touch_index,
    input  logic   touch_way,
    input  index_t query_index,
    output logic   victim_way
);

    // bit set means way 1 is the least recently used
    logic [SETS-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (touch_en) begin
            // the way not just used becomes the victim
            lru_bits[touch_index] <= ~touch_way;
        end
    end

    assign victim_way = lru_bits[query_index];

endmodule

//--- logic/dcache_ctrl.sv
// request buffer and main FSM, sequencing lookups, refills, store forwarding and the read return
`timescale 1ns/100ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // pipeline side
    input  logic      req_valid,
    input  logic      req_write,
    input  addr_t     req_addr,
    input  word_t     req_wdata,
    input  strb_t     req_wstrb,
    output logic      req_ready,
    output logic      rsp_valid,
    // array status
    input  way_mask_t hit,
    input  logic      victim_way,
    // memory side
    input  logic      mem_addr_ok,
    input  logic      mem_data_ok,
    input  line_t     mem_rdata,
    output logic      mem_req,
    output logic      mem_write,
    output addr_t     mem_addr,
    output word_t     mem_wdata,
    output strb_t     mem_wstrb,
    // tag RAM
    output tag_t      cmp_tag,
    output way_mask_t tag_wr_en,
    output index_t    wr_index,
    output tag_t      wr_tag,
    // data RAM
    output way_mask_t fill_en,
    output line_t     fill_line,
    output way_mask_t word_wr_en,
    output word_sel_t wr_word,
    output word_t     wr_data,
    output strb_t     wr_strb,
    // LRU
    output logic      touch_en,
    output logic      touch_way,
    output index_t    touch_index,
    output index_t    query_index,
    // read return
    output logic      sel_way,
    output logic      sel_mem,
    output word_sel_t sel_word
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    // request buffer
    logic  buf_write;
    addr_t buf_addr;
    word_t buf_wdata;
    strb_t buf_wstrb;

    tag_t      buf_tag;
    index_t    buf_index;
    word_sel_t buf_word;

    logic any_hit;
    logic load_hit;
    logic accept;
    logic refill_done;

    assign buf_tag   = buf_addr[ADDR_W-1 -: TAG_W];
    assign buf_index = buf_addr[OFFSET_W+2 +: INDEX_W];
    assign buf_word  = buf_addr[2 +: OFFSET_W];

    assign any_hit     = |hit;
    assign load_hit    = (state == LOOKUP) && !buf_write && any_hit;
    assign refill_done = (state == MISS_WAIT) && mem_data_ok;

    ////////////////////////////////////////////////////////////
    // pipeline handshake
    ////////////////////////////////////////////////////////////

    // a load hit frees the buffer for the next request in the same cycle
    assign req_ready = (state == IDLE) || load_hit;
    assign accept    = req_valid && req_ready;

    assign rsp_valid = load_hit || refill_done || ((state == WRITE_WAIT) && mem_data_ok);

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_write <= req_write;
            buf_addr  <= req_addr;
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    ////////////////////////////////////////////////////////////
    // main FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (buf_write) begin
                    state_next = WRITE_REQ;
                end else if (!any_hit) begin
                    state_next = MISS_REQ;
                end else if (!accept) begin
                    state_next = IDLE;
                end
            end
            MISS_REQ: begin
                if (mem_addr_ok) begin
                    state_next = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (mem_data_ok) begin
                    state_next = IDLE;
                end
            end
            WRITE_REQ: begin
                if (mem_addr_ok) begin
                    state_next = WRITE_WAIT;
                end
            end
            WRITE_WAIT: begin
                if (mem_data_ok) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // memory requests
    ////////////////////////////////////////////////////////////

    assign mem_req   = (state == MISS_REQ) || (state == WRITE_REQ);
    assign mem_write = (state == WRITE_REQ);
    // refill reads the aligned line, stores go out at word granularity
    assign mem_addr  = mem_write ? {buf_addr[ADDR_W-1:2], 2'b00}
                                 : {buf_tag, buf_index, {(OFFSET_W + 2){1'b0}}};
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

    ////////////////////////////////////////////////////////////
    // array updates
    ////////////////////////////////////////////////////////////

    assign cmp_tag  = buf_tag;
    assign wr_index = buf_index;
    assign wr_tag   = buf_tag;

    // victim stays fixed while the miss is outstanding, nothing touches the set
    assign tag_wr_en  = refill_done ? way_mask_t'(1 << victim_way) : '0;
    assign fill_en    = tag_wr_en;
    assign fill_line  = mem_rdata;

    // store hit updates the cached word during lookup
    assign word_wr_en = ((state == LOOKUP) && buf_write) ? hit : '0;
    assign wr_word    = buf_word;
    assign wr_data    = buf_wdata;
    assign wr_strb    = buf_wstrb;

    assign touch_en    = ((state == LOOKUP) && any_hit) || refill_done;
    assign touch_way   = refill_done ? victim_way : hit[1];
    assign touch_index = buf_index;
    assign query_index = buf_index;

    // read return
    assign sel_way  = hit[1];
    assign sel_mem  = (state == MISS_WAIT);
    assign sel_word = buf_word;

endmodule

//--- logic/dcache.sv
// top level of the two-way write-through data cache, connecting arrays, LRU and controller
`timescale 1ns/100ps

module dcache import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // pipeline side
    input  logic  req_valid,
    input  logic  req_write,
    input  addr_t req_addr,
    input  word_t req_wdata,
    input  strb_t req_wstrb,
    output logic  req_ready,
    output logic  rsp_valid,
    output word_t rsp_rdata,
    // memory side
    output logic  mem_req,
    output logic  mem_write,
    output addr_t mem_addr,
    output word_t mem_wdata,
    output strb_t mem_wstrb,
    input  logic  mem_addr_ok,
    input  logic  mem_data_ok,
    input  line_t mem_rdata
);

    index_t    rd_index;
    way_mask_t hit;
    logic      victim_way;

    tag_t      cmp_tag;
    way_mask_t tag_wr_en;
    index_t    wr_index;
    tag_t      wr_tag;

    way_mask_t fill_en;
    line_t     fill_line;
    way_mask_t word_wr_en;
    word_sel_t wr_word;
    word_t     wr_data;
    strb_t     wr_strb;
    line_t     rd_line0;
    line_t     rd_line1;

    logic      touch_en;
    logic      touch_way;
    index_t    touch_index;
    index_t    query_index;

    logic      sel_way;
    logic      sel_mem;
    word_sel_t sel_word;
    line_t     sel_line;

    // array read starts on the incoming address
    assign rd_index = req_addr[OFFSET_W+2 +: INDEX_W];

    dcache_tag_ram u_tag_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_index (rd_index),
        .cmp_tag  (cmp_tag),
        .wr_en    (tag_wr_en),
        .wr_index (wr_index),
        .wr_tag   (wr_tag),
        .hit      (hit)
    );

    dcache_data_ram u_data_ram (
        .clk       (clk),
        .rd_index  (rd_index),
        .fill_en   (fill_en),
        .fill_line (fill_line),
        .wr_en     (word_wr_en),
        .wr_index  (wr_index),
        .wr_word   (wr_word),
        .wr_data   (wr_data),
        .wr_strb   (wr_strb),
        .rd_line0  (rd_line0),
        .rd_line1  (rd_line1)
    );

    dcache_lru u_lru (
        .clk         (clk),
        .rst_n       (rst_n),
        .touch_en    (touch_en),
        .touch_index (touch_index),
        .touch_way   (touch_way),
        .query_index (query_index),
        .victim_way  (victim_way)
    );

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .hit         (hit),
        .victim_way  (victim_way),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .cmp_tag     (cmp_tag),
        .tag_wr_en   (tag_wr_en),
        .wr_index    (wr_index),
        .wr_tag      (wr_tag),
        .fill_en     (fill_en),
        .fill_line   (fill_line),
        .word_wr_en  (word_wr_en),
        .wr_word     (wr_word),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .touch_en    (touch_en),
        .touch_way   (touch_way),
        .touch_index (touch_index),
        .query_index (query_index),
        .sel_way     (sel_way),
        .sel_mem     (sel_mem),
        .sel_word    (sel_word)
    );

    ////////////////////////////////////////////////////////////
    // read return mux
    ////////////////////////////////////////////////////////////

    // refill data bypasses the arrays in the response cycle
    always_comb begin
        if (sel_mem) begin
            sel_line = mem_rdata;
        end else if (sel_way) begin
            sel_line = rd_line1;
        end else begin
            sel_line = rd_line0;
        end
    end

    assign rsp_rdata = sel_line[{sel_word, 5'b00000} +: 32];

endmodule

//--- bench/dcache_mem_model.sv
// memory model for the cache testbench, random addr_ok/data_ok delays over a pattern-filled word array
`timescale 1ns/100ps

module dcache_mem_model import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mem_req,
    input  logic  mem_write,
    input  addr_t mem_addr,
    input  word_t mem_wdata,
    input  strb_t mem_wstrb,
    output logic  mem_addr_ok,
    output logic  mem_data_ok,
    output line_t mem_rdata
);

    // covers the 1 KiB test window
    localparam int WORDS = 256;

    word_t mem_words [WORDS];

    // initial contents, every address bit takes part
    function automatic word_t word_pattern(input addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h3c5a_96e1;
    endfunction

    // outputs change just after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
        int    base;
        for (int i = 0; i < WORDS; i++) begin
            mem_words[i] = word_pattern(addr_t'(i) << 2);
        end
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_addr_ok = 1'b0;
            mem_data_ok = 1'b0;
            if (rst_n && mem_req) begin
                wait_cycles($urandom_range(0, 5));
                mem_addr_ok = 1'b1;
                write = mem_write;
                addr  = mem_addr;
                wdata = mem_wdata;
                wstrb = mem_wstrb;
                wait_cycles(1);
                mem_addr_ok = 1'b0;
                wait_cycles($urandom_range(0, 5));
                if (write) begin
                    base = addr[9:2];
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            mem_words[base][b * 8 +: 8] = wdata[b * 8 +: 8];
                        end
                    end
                end else begin
                    // word 0 of the line sits in the low bits
                    base = {addr[9:4], 2'b00};
                    for (int k = 0; k < 4; k++) begin
                        mem_rdata[k * 32 +: 32] = mem_words[base + k];
                    end
                end
                mem_data_ok = 1'b1;
            end
        end
    end

endmodule

//--- bench/dcache_tb.sv
// testbench for the data cache, random loads and stores checked against shadow memory and a tag/LRU model
`timescale 1ns/100ps

module dcache_tb import dcache_pkg::*; ();

    localparam int          N_RANDOM       = 600;
    localparam int          N_DIRECTED     = 7;
    localparam int          RESET_CYCLES   = 16;
    localparam int          TIMEOUT_CYCLES = (N_RANDOM + N_DIRECTED) * 20 + RESET_CYCLES;
    localparam int          WINDOW_WORDS   = 256;
    localparam int unsigned SEED           = 32'h65b6_a3b1;

    logic  clk;
    logic  rst_n;
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_wstrb;
    logic  req_ready;
    logic  rsp_valid;
    word_t rsp_rdata;
    logic  mem_req;
    logic  mem_write;
    addr_t mem_addr;
    word_t mem_wdata;
    strb_t mem_wstrb;
    logic  mem_addr_ok;
    logic  mem_data_ok;
    line_t mem_rdata;

    // shadow memory and tag/valid/LRU model
    word_t shadow      [WINDOW_WORDS];
    logic  model_valid [WAYS][SETS];
    tag_t  model_tag   [WAYS][SETS];
    logic  model_lru   [SETS];

    // expected responses and memory transactions, in order
    logic  exp_rsp_load [$];
    word_t exp_rsp_data [$];
    logic  exp_rsp_hit  [$];
    int    exp_rsp_cycle[$];
    logic  exp_mem_write[$];
    addr_t exp_mem_addr [$];
    word_t exp_mem_data [$];
    strb_t exp_mem_strb [$];

    int   cycle     = 0;
    int   sent      = 0;
    int   rsp_count = 0;
    int   errors    = 0;
    // line reads the DUT has issued so far
    int   mem_reads = 0;

    dcache dcache_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp_rdata   (rsp_rdata),
        .mem_req     (mem_req),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    dcache_mem_model mem_model_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req     (mem_req),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // same address pattern as the memory model starts from
    function automatic word_t word_pattern(input addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h3c5a_96e1;
    endfunction

    task automatic stop_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail at %0t: %s, got %h expected %h", $time, what, got, exp));
        end
    endtask

    // model update for one accepted request
    task automatic predict_request(input logic write, input addr_t addr, input word_t data,
                                   input strb_t strb);
        index_t idx;
        tag_t   tg;
        int     widx;
        logic   hit0;
        logic   hit1;
        logic   is_hit;
        logic   victim;
        idx    = addr[OFFSET_W+2 +: INDEX_W];
        tg     = addr[ADDR_W-1 -: TAG_W];
        widx   = addr[9:2];
        hit0   = model_valid[0][idx] && (model_tag[0][idx] == tg);
        hit1   = model_valid[1][idx] && (model_tag[1][idx] == tg);
        is_hit = hit0 || hit1;
        if (is_hit) begin
            model_lru[idx] = !hit1;
        end
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow[widx][b * 8 +: 8] = data[b * 8 +: 8];
                end
            end
            // write-through, no allocate on a miss
            exp_mem_write.push_back(1'b1);
            exp_mem_addr.push_back({addr[ADDR_W-1:2], 2'b00});
            exp_mem_data.push_back(data);
            exp_mem_strb.push_back(strb);
            exp_rsp_load.push_back(1'b0);
            exp_rsp_data.push_back('0);
            exp_rsp_hit.push_back(1'b0);
        end else begin
            exp_rsp_load.push_back(1'b1);
            exp_rsp_data.push_back(shadow[widx]);
            exp_rsp_hit.push_back(is_hit);
            if (!is_hit) begin
                victim = model_lru[idx];
                model_valid[victim][idx] = 1'b1;
                model_tag[victim][idx]   = tg;
                model_lru[idx]           = !victim;
                exp_mem_write.push_back(1'b0);
                exp_mem_addr.push_back({addr[ADDR_W-1:4], 4'b0000});
                exp_mem_data.push_back('0);
                exp_mem_strb.push_back('0);
            end
        end
        exp_rsp_cycle.push_back(cycle);
    endtask

    // called just after a rising edge, returns just after the transfer edge
    task automatic send_req(input logic write, input addr_t addr, input word_t data,
                            input strb_t strb);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        req_wstrb = strb;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        sent++;
    endtask

    // returns at a falling edge once every accepted request has its response
    task automatic wait_responses();
        while (rsp_count < sent) begin
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // clock, timeout and bus monitor
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle++;
            if (cycle > TIMEOUT_CYCLES) begin
                stop_run($sformatf("timeout after %0d cycles, %0d of %0d responses seen",
                                   cycle, rsp_count, sent));
            end
        end
    end

    // everything is settled at the falling edge
    always @(negedge clk) begin
        logic  e_load;
        word_t e_data;
        logic  e_hit;
        int    e_cycle;
        if (rsp_valid) begin
            if (exp_rsp_load.size() == 0) begin
                stop_run("response arrived with no request outstanding");
            end else begin
                e_load  = exp_rsp_load.pop_front();
                e_data  = exp_rsp_data.pop_front();
                e_hit   = exp_rsp_hit.pop_front();
                e_cycle = exp_rsp_cycle.pop_front();
                rsp_count++;
                if (e_load) begin
                    check_value("load data", rsp_rdata, e_data);
                end
                if (e_hit) begin
                    check_value("load hit response cycle", cycle, e_cycle + 1);
                end
            end
        end
        if (req_valid && req_ready) begin
            predict_request(req_write, req_addr, req_wdata, req_wstrb);
        end
        if (mem_req && mem_addr_ok) begin
            if (exp_mem_write.size() == 0) begin
                stop_run("memory transaction that the model did not predict");
            end else begin
                if (!mem_write) begin
                    mem_reads++;
                end
                e_load = !exp_mem_write.pop_front();
                check_value("memory write flag", mem_write, !e_load);
                check_value("memory address", mem_addr, exp_mem_addr.pop_front());
                e_data = exp_mem_data.pop_front();
                if (!e_load) begin
                    check_value("memory write data", mem_wdata, e_data);
                    check_value("memory write strobe", mem_wstrb, exp_mem_strb.pop_front());
                end else begin
                    void'(exp_mem_strb.pop_front());
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        logic        is_write;
        addr_t       addr;
        word_t       data;
        strb_t       strb;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            shadow[i] = word_pattern(addr_t'(i) << 2);
        end
        for (int s = 0; s < SETS; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s]   = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("req_ready after reset", req_ready, 1);
        check_value("rsp_valid after reset", rsp_valid, 0);
        check_value("mem_req after reset", mem_req, 0);
        @(posedge clk);
        #1;

        // set 3, A B A C must keep A
        send_req(1'b0, 32'h030, '0, '0);
        send_req(1'b0, 32'h130, '0, '0);
        send_req(1'b0, 32'h030, '0, '0);
        send_req(1'b0, 32'h230, '0, '0);
        send_req(1'b0, 32'h030, '0, '0);
        wait_responses();
        // only A, B and C miss, both later loads of A hit
        check_value("line reads after A B A C A", mem_reads, 3);
        @(posedge clk);
        #1;
        // store miss allocates nothing
        send_req(1'b1, 32'h334, 32'h1122_3344, 4'b0110);
        send_req(1'b0, 32'h334, '0, '0);
        wait_responses();
        check_value("line reads after load behind store miss", mem_reads, 4);
        @(posedge clk);
        #1;

        for (int i = 0; i < N_RANDOM; i++) begin
            is_write = ($urandom_range(0, 9) < 4);
            addr     = addr_t'($urandom_range(0, WINDOW_WORDS - 1)) << 2;
            data     = $urandom();
            strb     = strb_t'($urandom_range(1, 15));
            send_req(is_write, addr, data, strb);
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 2)) @(posedge clk);
                #1;
            end
        end

        wait_responses();
        // stray responses or memory requests would show up here
        repeat (10) @(negedge clk);
        check_value("memory transactions still expected", exp_mem_write.size(), 0);

        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- src.f
logic/dcache_pkg.sv
logic/dcache_tag_ram.sv
logic/dcache_data_ram.sv
logic/dcache_lru.sv
logic/dcache_ctrl.sv
logic/dcache.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv
